/* sim.f */
verilog/mm_ram_pkg.sv
verilog/mm_dp_ram.sv
verilog/mm_data_port.sv
verilog/mm_timer.sv
verilog/mm_ram.sv
verification/tb_mm_ram.sv

/* run_sim.sh */
#!/bin/sh
# Verilator build and run of the mm_ram testbench
cd "$(dirname "$0")" || exit 1

OBJ_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -f sim.f --top-module tb_mm_ram \
    --Mdir "$OBJ_DIR" -o Vtb_mm_ram
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "verilator build failed with status $build_status"
    exit 1
fi

"./$OBJ_DIR/Vtb_mm_ram" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "Result: FAILED" "$LOG"; then
    echo "simulation reported a failure, see $LOG"
    exit 1
fi

if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

exit 0

/* verification/tb_mm_ram.sv */
// memory model testbench
`timescale 1ns/1ps
`default_nettype none

module tb_mm_ram
    import mm_ram_pkg::*;
();

    localparam int          RAM_AW    = 16;
    localparam int          INSTR_W   = 128;
    localparam int          TIMEOUT   = 200;
    localparam logic [31:0] RAM_BYTES = 32'd1 << RAM_AW;
    // strobe order is print, passed, failed, exit
    localparam logic [3:0]  STB_PRINT = 4'b1000;
    localparam logic [3:0]  STB_PASS  = 4'b0100;
    localparam logic [3:0]  STB_FAIL  = 4'b0010;
    localparam logic [3:0]  STB_EXIT  = 4'b0001;

    typedef enum logic [1:0] {OP_WRITE, OP_READ, OP_PERIPH} op_e;

    // expected holds peripheral strobes, or the value of a read outside RAM
    typedef struct packed {
        op_e         op;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  be;
        logic [31:0] expected;
    } entry_t;

    logic               clk_i;
    logic               rst_ni;
    logic               instr_req_i;
    logic [RAM_AW-1:0]  instr_addr_i;
    logic               instr_gnt_o;
    logic               instr_rvalid_o;
    logic [INSTR_W-1:0] instr_rdata_o;
    logic               data_req_i;
    logic [31:0]        data_addr_i;
    logic               data_we_i;
    logic [3:0]         data_be_i;
    logic [31:0]        data_wdata_i;
    logic               data_gnt_o;
    logic               data_rvalid_o;
    logic [31:0]        data_rdata_o;
    logic               irq_ack_i;
    logic [4:0]         irq_id_i;
    logic               irq_timer_o;
    logic               print_valid_o;
    logic [7:0]         print_char_o;
    logic               tests_passed_o;
    logic               tests_failed_o;
    logic               exit_valid_o;
    logic [31:0]        exit_value_o;

    logic [7:0]         ref_mem [2**RAM_AW];
    logic [31:0]        lcg_state = 32'd79;
    entry_t             stim_q [$];
    int                 cycles;

    mm_ram u_mm_ram (.*);

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic logic [31:0] ref_word(logic [31:0] addr);
        logic [15:0] base;
        logic [31:0] word;
        base = {addr[15:2], 2'b00};
        for (int i = 0; i < 4; i++) begin
            word[8*i +: 8] = ref_mem[base + 16'(i)];
        end
        return word;
    endfunction

    // fetch line, lowest address in the low byte
    function automatic logic [INSTR_W-1:0] ref_line(logic [15:0] base);
        logic [INSTR_W-1:0] line;
        for (int i = 0; i < INSTR_W / 8; i++) begin
            line[8*i +: 8] = ref_mem[base + 16'(i)];
        end
        return line;
    endfunction

    task automatic ref_store(logic [31:0] addr, logic [31:0] wdata, logic [3:0] be);
        logic [15:0] base;
        base = {addr[15:2], 2'b00};
        for (int i = 0; i < 4; i++) begin
            if (be[i])
                ref_mem[base + 16'(i)] = wdata[8*i +: 8];
        end
    endtask

    task automatic report_fail(string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        assert (got === exp)
        else report_fail($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
    endtask

    task automatic check_word(string name, logic [31:0] got, logic [31:0] exp);
        assert (got === exp)
        else report_fail($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
    endtask

    task automatic check_line(string name, logic [INSTR_W-1:0] got, logic [INSTR_W-1:0] exp);
        assert (got === exp)
        else report_fail($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
    endtask

    task automatic add_entry(op_e op, logic [31:0] addr, logic [31:0] wdata,
                             logic [3:0] be, logic [31:0] expected);
        stim_q.push_back(entry_t'{op, addr, wdata, be, expected});
    endtask

    // single full-word write, response checked one cycle later
    task automatic issue_write(logic [31:0] addr, logic [31:0] data);
        @(negedge clk_i);
        data_req_i   = 1'b1;
        data_we_i    = 1'b1;
        data_addr_i  = addr;
        data_be_i    = 4'hf;
        data_wdata_i = data;
        @(negedge clk_i);
        data_req_i = 1'b0;
        data_we_i  = 1'b0;
        check_bit("data_rvalid_o", data_rvalid_o, 1'b1);
    endtask

    task automatic wait_irq(input logic level, output int count);
        count = 0;
        while (irq_timer_o !== level) begin
            @(negedge clk_i);
            count++;
            if (count > TIMEOUT)
                report_fail("timer interrupt did not reach the expected level in time");
        end
    endtask

    // one request per cycle, each response checked while the next one is issued
    task automatic run_table();
        entry_t      e;
        logic        prev_rd;
        logic [31:0] prev_exp;
        logic [3:0]  exp_stb;
        prev_rd  = 1'b0;
        prev_exp = '0;
        for (int i = 0; i <= stim_q.size(); i++) begin
            @(negedge clk_i);
            if (i > 0) begin
                check_bit("data_rvalid_o", data_rvalid_o, 1'b1);
                if (prev_rd)
                    check_word("data_rdata_o", data_rdata_o, prev_exp);
            end
            if (i == stim_q.size()) begin
                data_req_i = 1'b0;
                data_we_i  = 1'b0;
            end else begin
                e            = stim_q[i];
                data_req_i   = 1'b1;
                data_we_i    = e.op != OP_READ;
                data_addr_i  = e.addr;
                data_be_i    = e.be;
                data_wdata_i = e.wdata;
                prev_rd      = e.op == OP_READ;
                prev_exp     = (e.addr < RAM_BYTES) ? ref_word(e.addr) : e.expected;
                exp_stb      = (e.op == OP_PERIPH) ? e.expected[3:0] : 4'b0000;
                if (e.op == OP_WRITE)
                    ref_store(e.addr, e.wdata, e.be);
                #1;
                check_bit("data_gnt_o", data_gnt_o, 1'b1);
                check_bit("print_valid_o", print_valid_o, exp_stb[3]);
                check_bit("tests_passed_o", tests_passed_o, exp_stb[2]);
                check_bit("tests_failed_o", tests_failed_o, exp_stb[1]);
                check_bit("exit_valid_o", exit_valid_o, exp_stb[0]);
                if (exp_stb[3])
                    check_word("print_char_o", {24'd0, print_char_o}, {24'd0, e.wdata[7:0]});
                if (exp_stb[0])
                    check_word("exit_value_o", exit_value_o, e.wdata);
            end
        end
        @(negedge clk_i);
        check_bit("data_rvalid_o", data_rvalid_o, 1'b0);
    endtask

    initial begin
        rst_ni       = 1'b0;
        instr_req_i  = 1'b0;
        instr_addr_i = '0;
        data_req_i   = 1'b0;
        data_addr_i  = '0;
        data_we_i    = 1'b0;
        data_be_i    = '0;
        data_wdata_i = '0;
        irq_ack_i    = 1'b0;
        irq_id_i     = '0;

        // full words first so no byte is read before it is written
        add_entry(OP_WRITE, 32'h0000_0100, lcg_next(), 4'hf, '0);
        add_entry(OP_WRITE, 32'h0000_0104, lcg_next(), 4'hf, '0);
        add_entry(OP_WRITE, 32'h0000_0108, lcg_next(), 4'hf, '0);
        add_entry(OP_WRITE, 32'h0000_fffc, lcg_next(), 4'hf, '0);
        add_entry(OP_WRITE, 32'h0000_0100, lcg_next(), 4'h1, '0);
        add_entry(OP_WRITE, 32'h0000_0104, lcg_next(), 4'h6, '0);
        add_entry(OP_WRITE, 32'h0000_0108, lcg_next(), 4'h8, '0);
        add_entry(OP_WRITE, 32'h0000_fffc, lcg_next(), 4'hc, '0);
        add_entry(OP_READ,  32'h0000_0100, '0, 4'hf, '0);
        add_entry(OP_READ,  32'h0000_0106, '0, 4'hf, '0);
        add_entry(OP_READ,  32'h0000_0108, '0, 4'hf, '0);
        add_entry(OP_READ,  32'h0000_fffc, '0, 4'hf, '0);
        add_entry(OP_WRITE, 32'h0000_0104, lcg_next(), 4'h3, '0);
        add_entry(OP_READ,  32'h0000_0104, '0, 4'hf, '0);
        // low words that the addresses below alias onto when truncated
        add_entry(OP_WRITE, 32'h0000_0000, lcg_next() | 32'h0000_0001, 4'hf, '0);
        add_entry(OP_WRITE, 32'h0000_0004, lcg_next() | 32'h0000_0001, 4'hf, '0);
        // outside RAM everything reads as zero
        add_entry(OP_READ,  32'h0001_0000, '0, 4'hf, '0);
        add_entry(OP_READ,  32'h3000_0000, '0, 4'hf, '0);
        add_entry(OP_READ,  PRINT_ADDR, '0, 4'hf, '0);
        add_entry(OP_READ,  TIMER_COUNT_ADDR, '0, 4'hf, '0);
        add_entry(OP_PERIPH, TEST_STATUS_ADDR, TEST_PASS_CODE, 4'hf, 32'(STB_PASS));
        add_entry(OP_PERIPH, TEST_STATUS_ADDR, TEST_FAIL_CODE, 4'hf, 32'(STB_FAIL));
        add_entry(OP_PERIPH, TEST_STATUS_ADDR, lcg_next() | 32'h8000_0000, 4'hf, '0);
        add_entry(OP_PERIPH, EXIT_ADDR, lcg_next(), 4'hf, 32'(STB_EXIT));
        add_entry(OP_PERIPH, PRINT_ADDR, lcg_next(), 4'hf, 32'(STB_PRINT));

        repeat (4) @(negedge clk_i);
        rst_ni = 1'b1;
        check_bit("data_rvalid_o", data_rvalid_o, 1'b0);
        check_bit("instr_rvalid_o", instr_rvalid_o, 1'b0);
        check_bit("irq_timer_o", irq_timer_o, 1'b0);

        run_table();

        // two fetch lines written through the data port
        for (int i = 0; i < 8; i++) begin
            lcg_state = lcg_next();
            issue_write(32'h0000_0200 + 32'(4 * i), lcg_state);
            ref_store(32'h0000_0200 + 32'(4 * i), lcg_state, 4'hf);
        end
        @(negedge clk_i);
        instr_req_i  = 1'b1;
        instr_addr_i = 16'h0200;
        #1;
        check_bit("instr_gnt_o", instr_gnt_o, 1'b1);
        @(negedge clk_i);
        check_bit("instr_rvalid_o", instr_rvalid_o, 1'b1);
        check_line("instr_rdata_o", instr_rdata_o, ref_line(16'h0200));
        instr_addr_i = 16'h0210;
        @(negedge clk_i);
        check_bit("instr_rvalid_o", instr_rvalid_o, 1'b1);
        check_line("instr_rdata_o", instr_rdata_o, ref_line(16'h0210));
        instr_req_i = 1'b0;
        @(negedge clk_i);
        check_bit("instr_rvalid_o", instr_rvalid_o, 1'b0);

        // timer with its mask bit set fires N edges after the load
        issue_write(TIMER_MASK_ADDR, 32'd1 << TIMER_IRQ_ID);
        issue_write(TIMER_COUNT_ADDR, 32'd9);
        check_bit("irq_timer_o", irq_timer_o, 1'b0);
        wait_irq(1'b1, cycles);
        check_word("timer rise cycle", cycles, 32'd9);
        irq_ack_i = 1'b1;
        irq_id_i  = 5'd3;
        @(negedge clk_i);
        check_bit("irq_timer_o", irq_timer_o, 1'b1);
        irq_id_i = TIMER_IRQ_ID;
        wait_irq(1'b0, cycles);
        check_word("timer clear cycle", cycles, 32'd1);
        irq_ack_i = 1'b0;
        irq_id_i  = '0;

        // masked timer stays quiet
        issue_write(TIMER_MASK_ADDR, '0);
        issue_write(TIMER_COUNT_ADDR, 32'd6);
        for (int i = 0; i < 6 + 5; i++) begin
            @(negedge clk_i);
            check_bit("irq_timer_o", irq_timer_o, 1'b0);
        end

        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/mm_ram.sv */
// memory and pseudo-peripheral model
`timescale 1ns/1ps
`default_nettype none

module mm_ram
    import mm_ram_pkg::*;
#(
    parameter int unsigned RAM_ADDR_WIDTH    = 16,
    parameter int unsigned INSTR_RDATA_WIDTH = 128
) (
    input  wire logic                          clk_i,
    input  wire logic                          rst_ni,

    // instruction fetch
    input  wire logic                          instr_req_i,
    input  wire logic [RAM_ADDR_WIDTH-1:0]     instr_addr_i,
    output logic                               instr_gnt_o,
    output logic                               instr_rvalid_o,
    output logic [INSTR_RDATA_WIDTH-1:0]       instr_rdata_o,

    // data access
    input  wire logic                          data_req_i,
    input  wire logic [31:0]                   data_addr_i,
    input  wire logic                          data_we_i,
    input  wire logic [BE_WIDTH-1:0]           data_be_i,
    input  wire logic [DATA_WIDTH-1:0]         data_wdata_i,
    output logic                               data_gnt_o,
    output logic                               data_rvalid_o,
    output logic [DATA_WIDTH-1:0]              data_rdata_o,

    // interrupt
    input  wire logic                          irq_ack_i,
    input  wire logic [4:0]                    irq_id_i,
    output logic                               irq_timer_o,

    // print and test status
    output logic                               print_valid_o,
    output logic [7:0]                         print_char_o,
    output logic                               tests_passed_o,
    output logic                               tests_failed_o,
    output logic                               exit_valid_o,
    output logic [DATA_WIDTH-1:0]              exit_value_o
);

    logic                      ram_req;
    logic [RAM_ADDR_WIDTH-1:0] ram_addr;
    logic                      ram_we;
    logic [BE_WIDTH-1:0]       ram_be;
    logic [DATA_WIDTH-1:0]     ram_wdata;
    logic [DATA_WIDTH-1:0]     ram_rdata;

    logic                      timer_mask_we;
    logic                      timer_count_we;
    logic [DATA_WIDTH-1:0]     timer_wdata;

    mm_data_port #(
        .RAM_ADDR_WIDTH (RAM_ADDR_WIDTH)
    ) u_data_port (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .data_req_i       (data_req_i),
        .data_addr_i      (data_addr_i),
        .data_we_i        (data_we_i),
        .data_be_i        (data_be_i),
        .data_wdata_i     (data_wdata_i),
        .data_gnt_o       (data_gnt_o),
        .data_rvalid_o    (data_rvalid_o),
        .data_rdata_o     (data_rdata_o),
        .ram_req_o        (ram_req),
        .ram_addr_o       (ram_addr),
        .ram_we_o         (ram_we),
        .ram_be_o         (ram_be),
        .ram_wdata_o      (ram_wdata),
        .ram_rdata_i      (ram_rdata),
        .timer_mask_we_o  (timer_mask_we),
        .timer_count_we_o (timer_count_we),
        .timer_wdata_o    (timer_wdata),
        .print_valid_o    (print_valid_o),
        .print_char_o     (print_char_o),
        .tests_passed_o   (tests_passed_o),
        .tests_failed_o   (tests_failed_o),
        .exit_valid_o     (exit_valid_o),
        .exit_value_o     (exit_value_o)
    );

    mm_dp_ram #(
        .RAM_ADDR_WIDTH    (RAM_ADDR_WIDTH),
        .INSTR_RDATA_WIDTH (INSTR_RDATA_WIDTH)
    ) u_dp_ram (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .instr_req_i    (instr_req_i),
        .instr_addr_i   (instr_addr_i),
        .instr_gnt_o    (instr_gnt_o),
        .instr_rvalid_o (instr_rvalid_o),
        .instr_rdata_o  (instr_rdata_o),
        .ram_req_i      (ram_req),
        .ram_addr_i     (ram_addr),
        .ram_we_i       (ram_we),
        .ram_be_i       (ram_be),
        .ram_wdata_i    (ram_wdata),
        .ram_rdata_o    (ram_rdata)
    );

    mm_timer u_timer (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .timer_mask_we_i  (timer_mask_we),
        .timer_count_we_i (timer_count_we),
        .timer_wdata_i    (timer_wdata),
        .irq_ack_i        (irq_ack_i),
        .irq_id_i         (irq_id_i),
        .irq_timer_o      (irq_timer_o)
    );

endmodule

`default_nettype wire

/* verilog/mm_timer.sv */
// countdown timer
`timescale 1ns/1ps
`default_nettype none

module mm_timer
    import mm_ram_pkg::*;
(
    input  wire logic                  clk_i,
    input  wire logic                  rst_ni,

    input  wire logic                  timer_mask_we_i,
    input  wire logic                  timer_count_we_i,
    input  wire logic [DATA_WIDTH-1:0] timer_wdata_i,

    input  wire logic                  irq_ack_i,
    input  wire logic [4:0]            irq_id_i,
    output logic                       irq_timer_o
);

    // only the timer's own bit of the mask word matters here
    logic                  mask_en_q;
    logic [DATA_WIDTH-1:0] count_q;
    logic                  irq_q;
    logic                  ack_hit;

    assign ack_hit = irq_ack_i && irq_id_i == TIMER_IRQ_ID;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            mask_en_q <= 1'b0;
            count_q   <= '0;
            irq_q     <= 1'b0;
        end else if (timer_mask_we_i) begin
            mask_en_q <= timer_wdata_i[TIMER_IRQ_ID];
        end else if (timer_count_we_i) begin
            count_q <= timer_wdata_i;
        end else begin
            if (count_q != '0) begin
                count_q <= count_q - 1'b1;
            end
            // fire on the 1 -> 0 step
            if (count_q == DATA_WIDTH'(1) && mask_en_q) begin
                irq_q <= 1'b1;
            end
            if (ack_hit) begin
                irq_q <= 1'b0;
            end
        end
    end

    assign irq_timer_o = irq_q;

    masked_irq_stays_low: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        $rose(irq_timer_o) |-> $past(mask_en_q)
    );

endmodule

`default_nettype wire

/* verilog/mm_data_port.sv */
// data port decoder and response
`timescale 1ns/1ps
`default_nettype none

module mm_data_port
    import mm_ram_pkg::*;
#(
    parameter int unsigned RAM_ADDR_WIDTH = 16
) (
    input  wire logic                      clk_i,
    input  wire logic                      rst_ni,

    // core data port
    input  wire logic                      data_req_i,
    input  wire logic [31:0]               data_addr_i,
    input  wire logic                      data_we_i,
    input  wire logic [BE_WIDTH-1:0]       data_be_i,
    input  wire logic [DATA_WIDTH-1:0]     data_wdata_i,
    output logic                           data_gnt_o,
    output logic                           data_rvalid_o,
    output logic [DATA_WIDTH-1:0]          data_rdata_o,

    // memory port B
    output logic                           ram_req_o,
    output logic [RAM_ADDR_WIDTH-1:0]      ram_addr_o,
    output logic                           ram_we_o,
    output logic [BE_WIDTH-1:0]            ram_be_o,
    output logic [DATA_WIDTH-1:0]          ram_wdata_o,
    input  wire logic [DATA_WIDTH-1:0]     ram_rdata_i,

    // timer register writes
    output logic                           timer_mask_we_o,
    output logic                           timer_count_we_o,
    output logic [DATA_WIDTH-1:0]          timer_wdata_o,

    // pseudo peripherals
    output logic                           print_valid_o,
    output logic [7:0]                     print_char_o,
    output logic                           tests_passed_o,
    output logic                           tests_failed_o,
    output logic                           exit_valid_o,
    output logic [DATA_WIDTH-1:0]          exit_value_o
);

    // one bit wider than the address so a full 32-bit RAM still fits
    localparam logic [32:0] RAM_SIZE = 33'd1 << RAM_ADDR_WIDTH;

    logic       ram_hit;
    logic       wr_req;
    logic       hit_print;
    logic       hit_status;
    logic       hit_exit;
    logic       hit_mask;
    logic       hit_count;
    rdata_sel_e sel_d;
    rdata_sel_e sel_q;
    logic       rvalid_q;

    assign ram_hit = {1'b0, data_addr_i} < RAM_SIZE;
    assign wr_req  = data_req_i && data_we_i;

    assign hit_print  = data_addr_i == PRINT_ADDR;
    assign hit_status = data_addr_i == TEST_STATUS_ADDR;
    assign hit_exit   = data_addr_i == EXIT_ADDR;
    assign hit_mask   = data_addr_i == TIMER_MASK_ADDR;
    assign hit_count  = data_addr_i == TIMER_COUNT_ADDR;

    // memory sees only requests inside its range
    assign ram_req_o   = data_req_i && ram_hit;
    assign ram_addr_o  = data_addr_i[RAM_ADDR_WIDTH-1:0];
    assign ram_we_o    = data_we_i;
    assign ram_be_o    = data_be_i;
    assign ram_wdata_o = data_wdata_i;

    // peripheral writes are single-cycle pulses
    assign print_valid_o  = wr_req && hit_print;
    assign print_char_o   = data_wdata_i[7:0];
    assign tests_passed_o = wr_req && hit_status && data_wdata_i == TEST_PASS_CODE;
    assign tests_failed_o = wr_req && hit_status && data_wdata_i == TEST_FAIL_CODE;
    assign exit_valid_o   = wr_req && hit_exit;
    assign exit_value_o   = data_wdata_i;

    assign timer_mask_we_o  = wr_req && hit_mask;
    assign timer_count_we_o = wr_req && hit_count;
    assign timer_wdata_o    = data_wdata_i;

    // only RAM reads return data, everything else reads as zero
    always_comb begin
        sel_d = SEL_ZERO;
        if (ram_hit && !data_we_i) begin
            sel_d = SEL_RAM;
        end
    end

    // no back-pressure, so the response always follows one cycle later
    assign data_gnt_o = data_req_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rvalid_q <= 1'b0;
            sel_q    <= SEL_ZERO;
        end else begin
            rvalid_q <= data_req_i;
            if (data_req_i) begin
                sel_q <= sel_d;
            end
        end
    end

    assign data_rvalid_o = rvalid_q;
    assign data_rdata_o  = (sel_q == SEL_RAM) ? ram_rdata_i : '0;

    // writes outside the map point at a broken program
    write_in_map: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        wr_req |-> ram_hit || hit_print || hit_status || hit_exit
                   || hit_mask || hit_count
    );

endmodule

`default_nettype wire

/* verilog/mm_dp_ram.sv */
// dual-port byte memory
`timescale 1ns/1ps
`default_nettype none

module mm_dp_ram
    import mm_ram_pkg::*;
#(
    parameter int unsigned RAM_ADDR_WIDTH    = 16,
    parameter int unsigned INSTR_RDATA_WIDTH = 128
) (
    input  wire logic                         clk_i,
    input  wire logic                         rst_ni,

    input  wire logic                         instr_req_i,
    input  wire logic [RAM_ADDR_WIDTH-1:0]    instr_addr_i,
    output logic                              instr_gnt_o,
    output logic                              instr_rvalid_o,
    output logic [INSTR_RDATA_WIDTH-1:0]      instr_rdata_o,

    input  wire logic                         ram_req_i,
    input  wire logic [RAM_ADDR_WIDTH-1:0]    ram_addr_i,
    input  wire logic                         ram_we_i,
    input  wire logic [BE_WIDTH-1:0]          ram_be_i,
    input  wire logic [DATA_WIDTH-1:0]        ram_wdata_i,
    output logic [DATA_WIDTH-1:0]             ram_rdata_o
);

    localparam int unsigned INSTR_BYTES = INSTR_RDATA_WIDTH / 8;

    logic [7:0]                   mem [2**RAM_ADDR_WIDTH];

    logic [RAM_ADDR_WIDTH-1:0]    instr_base;
    logic [RAM_ADDR_WIDTH-1:0]    data_base;
    logic                         instr_rvalid_q;
    logic [INSTR_RDATA_WIDTH-1:0] instr_rdata_q;
    logic [DATA_WIDTH-1:0]        ram_rdata_q;

    // both ports work on word-aligned addresses
    assign instr_base = {instr_addr_i[RAM_ADDR_WIDTH-1:2], 2'b00};
    assign data_base  = {ram_addr_i[RAM_ADDR_WIDTH-1:2], 2'b00};

    // port A never stalls
    assign instr_gnt_o = instr_req_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            instr_rvalid_q <= 1'b0;
        end else begin
            instr_rvalid_q <= instr_req_i;
        end
    end

    // wide fetch, lowest address lands in the low byte
    always_ff @(posedge clk_i) begin
        if (instr_req_i) begin
            for (int i = 0; i < INSTR_BYTES; i++) begin
                instr_rdata_q[8*i +: 8] <= mem[instr_base + RAM_ADDR_WIDTH'(i)];
            end
        end
    end

    // port B: byte-enabled write or full word read
    always_ff @(posedge clk_i) begin
        if (ram_req_i) begin
            for (int i = 0; i < BE_WIDTH; i++) begin
                if (ram_we_i && ram_be_i[i]) begin
                    mem[data_base + RAM_ADDR_WIDTH'(i)] <= ram_wdata_i[8*i +: 8];
                end
                if (!ram_we_i) begin
                    ram_rdata_q[8*i +: 8] <= mem[data_base + RAM_ADDR_WIDTH'(i)];
                end
            end
        end
    end

    assign instr_rvalid_o = instr_rvalid_q;
    assign instr_rdata_o  = instr_rdata_q;
    assign ram_rdata_o    = ram_rdata_q;

    // a store from the core always carries at least one byte
    ram_write_has_bytes: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        ram_req_i && ram_we_i |-> ram_be_i != '0
    );

endmodule

`default_nettype wire

/* verilog/mm_ram_pkg.sv */
// memory model shared definitions
`default_nettype none

package mm_ram_pkg;

    // data port geometry
    localparam int unsigned DATA_WIDTH = 32;
    localparam int unsigned BE_WIDTH   = DATA_WIDTH / 8;

    // character output
    localparam logic [31:0] PRINT_ADDR = 32'h1000_0000;

    // test result reporting
    localparam logic [31:0] TEST_STATUS_ADDR = 32'h2000_0000;
    localparam logic [31:0] EXIT_ADDR        = 32'h2000_0004;

    // countdown timer registers
    localparam logic [31:0] TIMER_MASK_ADDR  = 32'h1500_0000;
    localparam logic [31:0] TIMER_COUNT_ADDR = 32'h1500_0004;

    // values written to TEST_STATUS_ADDR
    localparam logic [31:0] TEST_PASS_CODE = 32'd123456789;
    localparam logic [31:0] TEST_FAIL_CODE = 32'd1;

    // timer interrupt id, also the mask bit that enables it
    localparam logic [4:0] TIMER_IRQ_ID = 5'd7;

    // source of the data read response
    typedef enum logic [1:0] {
        SEL_RAM,
        SEL_ZERO
    } rdata_sel_e;

endpackage

`default_nettype wire
